/* common/mcu_bus_pkg.sv */
package mcu_bus_pkg;

	localparam int bus_aw = 32;
	localparam int bus_dw = 32;
	localparam int bus_sw = bus_dw / 8; // one enable per byte lane

	typedef logic [bus_aw-1:0] bus_addr_t; // byte address
	typedef logic [bus_dw-1:0] bus_data_t;
	typedef logic [bus_sw-1:0] bus_strb_t; // any bit set makes it a write
	typedef logic [15:0] reg_off_t; // register select inside the page

	localparam logic [15:0] periph_page = 16'hffff; // top half of every periph address

	// target dataslot parameter block
	localparam reg_off_t off_slot_id         = 16'hff80;
	localparam reg_off_t off_slot_bridgeaddr = 16'hff84;
	localparam reg_off_t off_slot_length     = 16'hff88;
	localparam reg_off_t off_slot_offset     = 16'hff8c;
	localparam reg_off_t off_slot_ctrl       = 16'hff90; // cmd on write, status on read

	localparam reg_off_t off_reset_out       = 16'hffa4;

	// update events from the bridge
	localparam reg_off_t off_irq             = 16'hffb0; // read clears
	localparam reg_off_t off_update_id       = 16'hffb4;
	localparam reg_off_t off_update_size     = 16'hffb8;

	localparam reg_off_t off_timer           = 16'hffc8; // ms count
	localparam reg_off_t off_hps_io          = 16'hffd0;

	// hps io word, data sits in bits 15..0
	localparam int hps_clk_bit = 17; // write side
	localparam int hps_ss0_bit = 18;
	localparam int hps_ss1_bit = 19;
	localparam int hps_ss2_bit = 20;
	localparam int hps_ack_bit = 17; // read side, wide flag just below it

endpackage

/* common/mcu_slot_pkg.sv */
package mcu_slot_pkg;

	typedef logic [15:0] slot_id_t;
	typedef logic [31:0] slot_word_t; // bridge addr, length, offset, update size
	typedef logic [2:0]  slot_err_t;  // zero is ok

	typedef logic [31:0] ms_count_t;
	typedef logic [15:0] hps_word_t;

	// status word on a read of the ctrl offset
	localparam int st_err_lsb    = 0;
	localparam int st_err_msb    = 2;
	localparam int st_done_bit   = 3;
	localparam int st_ack_bit    = 4;

	// command bits on a write of the ctrl offset
	localparam int ctrl_read_bit  = 0;
	localparam int ctrl_write_bit = 1;

endpackage

/* hw/dataslot/target_slot_regs.sv */
module target_slot_regs (
	input  logic                     clk_sys,
	input  logic                     reset_n,
	input  mcu_bus_pkg::bus_data_t   reg_wdata,
	input  logic                     wr_slot_id,
	input  logic                     wr_slot_bridgeaddr,
	input  logic                     wr_slot_length,
	input  logic                     wr_slot_offset,
	input  logic                     wr_slot_ctrl,
	input  logic                     slot_ack,  // up from cmd start to finish
	input  logic                     slot_done, // up from finish to next cmd
	input  mcu_slot_pkg::slot_err_t  slot_err,
	output mcu_slot_pkg::slot_id_t   slot_id_q,
	output mcu_slot_pkg::slot_word_t slot_bridgeaddr_q,
	output mcu_slot_pkg::slot_word_t slot_length_q,
	output mcu_slot_pkg::slot_word_t slot_offset_q,
	output logic                     slot_read,
	output logic                     slot_write,
	output mcu_bus_pkg::bus_data_t   slot_status
);

	always_ff @(posedge clk_sys or negedge reset_n) begin
		if (!reset_n) begin
			slot_id_q         <= '0;
			slot_bridgeaddr_q <= '0;
			slot_length_q     <= '0;
			slot_offset_q     <= '0;
			slot_read         <= 1'b0;
			slot_write        <= 1'b0;
		end else begin
			// cmd pulses, one cycle after the ctrl strobe ends
			slot_read  <= wr_slot_ctrl & reg_wdata[mcu_slot_pkg::ctrl_read_bit];
			slot_write <= wr_slot_ctrl & reg_wdata[mcu_slot_pkg::ctrl_write_bit];
			if (wr_slot_id)
				slot_id_q <= reg_wdata[15:0]; // upper half ignored
			if (wr_slot_bridgeaddr)
				slot_bridgeaddr_q <= reg_wdata;
			if (wr_slot_length)
				slot_length_q <= reg_wdata;
			if (wr_slot_offset)
				slot_offset_q <= reg_wdata;
		end
	end

	// status word, live from the target side
	always_comb begin
		slot_status = '0;
		slot_status[mcu_slot_pkg::st_err_msb:mcu_slot_pkg::st_err_lsb] = slot_err;
		slot_status[mcu_slot_pkg::st_done_bit] = slot_done;
		slot_status[mcu_slot_pkg::st_ack_bit]  = slot_ack;
	end

endmodule

/* hw/dataslot/slot_update_sync.sv */
module slot_update_sync (
	input  logic                     clk_sys,
	input  logic                     clk_74a,
	input  logic                     reset_n,
	input  logic                     update_pulse, // one clk_74a cycle
	input  mcu_slot_pkg::slot_id_t   update_id_in,
	input  mcu_slot_pkg::slot_word_t update_size_in,
	input  logic                     irq_clear,    // one clk_sys cycle
	output logic                     irq_out,
	output mcu_slot_pkg::slot_id_t   update_id,
	output mcu_slot_pkg::slot_word_t update_size
);

	logic                     upd_flag;  // bridge side pending flag
	logic [2:0]               clr_sync;  // irq_clear into clk_74a
	logic [2:0]               flag_sync; // upd_flag into clk_sys
	mcu_slot_pkg::slot_id_t   cap_id;    // captured with the event
	mcu_slot_pkg::slot_word_t cap_size;
	mcu_slot_pkg::slot_id_t   id_s1, id_s2;
	mcu_slot_pkg::slot_word_t size_s1, size_s2;

	// clk_74a side
	always_ff @(posedge clk_74a or negedge reset_n) begin
		if (!reset_n) begin
			clr_sync <= '0;
			upd_flag <= 1'b0;
		end else begin
			clr_sync <= {clr_sync[1:0], irq_clear};
			if (update_pulse)
				upd_flag <= 1'b1; // a new event wins over a clear
			else if (clr_sync[2])
				upd_flag <= 1'b0; // clear out of the last stage
		end
	end

	always_ff @(posedge clk_74a) begin
		if (update_pulse) begin
			cap_id   <= update_id_in;
			cap_size <= update_size_in;
		end
	end

	// clk_sys side
	always_ff @(posedge clk_sys or negedge reset_n) begin
		if (!reset_n) begin
			flag_sync <= '0;
			irq_out   <= 1'b0;
		end else begin
			flag_sync <= {flag_sync[1:0], upd_flag};
			irq_out   <= &flag_sync; // all three stages agree
		end
	end

	// capture regs are quiet well before the flag lands, so three stages settle them
	always_ff @(posedge clk_sys) begin
		id_s1       <= cap_id;
		id_s2       <= id_s1;
		update_id   <= id_s2;
		size_s1     <= cap_size;
		size_s2     <= size_s1;
		update_size <= size_s2;
	end

endmodule

/* hw/ms_timer.sv */
module ms_timer #(
	parameter int unsigned ticks_per_ms = 1000
) (
	input  logic                    clk_sys,
	input  logic                    reset_n,
	output mcu_slot_pkg::ms_count_t ms_count
);

	typedef logic [$clog2(ticks_per_ms + 1)-1:0] presc_t;

	localparam presc_t presc_last = presc_t'(ticks_per_ms - 1);

	presc_t presc; // clk_sys cycles inside the current ms

	always_ff @(posedge clk_sys or negedge reset_n) begin
		if (!reset_n) begin
			presc    <= '0;
			ms_count <= '0;
		end else if (presc == presc_last) begin
			presc    <= '0;
			ms_count <= ms_count + 1'b1; // wraps
		end else begin
			presc <= presc + 1'b1;
		end
	end

endmodule

/* hw/hps_io_port.sv */
module hps_io_port (
	input  logic                    clk_sys,
	input  logic                    reset_n,
	input  mcu_bus_pkg::bus_data_t  reg_wdata,
	input  logic                    wr_hps_io,
	input  logic                    io_wait,
	input  logic                    io_wide, // 1 for 16 bit, 0 for 8 bit
	input  mcu_slot_pkg::hps_word_t io_din,
	output mcu_slot_pkg::hps_word_t io_dout,
	output logic                    io_uio,
	output logic                    io_fpga,
	output logic                    io_strobe,
	output mcu_bus_pkg::bus_data_t  hps_status
);

	logic io_clk; // sw driven clock, half of the strobe
	logic io_ss0, io_ss1, io_ss2;
	logic rack;   // last io_clk level the core has seen
	logic io_ack;

	always_ff @(posedge clk_sys or negedge reset_n) begin
		if (!reset_n) begin
			io_clk <= 1'b0;
			io_ss0 <= 1'b0;
			io_ss1 <= 1'b0;
			io_ss2 <= 1'b0;
			rack   <= 1'b0;
			io_ack <= 1'b0;
		end else begin
			if (wr_hps_io) begin
				io_clk <= reg_wdata[mcu_bus_pkg::hps_clk_bit];
				io_ss0 <= reg_wdata[mcu_bus_pkg::hps_ss0_bit];
				io_ss1 <= reg_wdata[mcu_bus_pkg::hps_ss1_bit];
				io_ss2 <= reg_wdata[mcu_bus_pkg::hps_ss2_bit];
			end
			// the core stalls the handshake by holding wait
			if (!io_wait || io_strobe) begin
				rack   <= io_clk;
				io_ack <= rack;
			end
		end
	end

	always_ff @(posedge clk_sys) begin
		if (wr_hps_io)
			io_dout <= reg_wdata[15:0];
	end

	assign io_strobe = io_clk & ~rack; // new clock level not yet taken
	assign io_fpga   = io_ss0 & ~io_ss1; // command to the fpga
	assign io_uio    = io_ss2 & ~io_ss1; // broadcast, ss1 masks both

	always_comb begin
		hps_status = '0;
		hps_status[15:0] = io_din;
		hps_status[mcu_bus_pkg::hps_ack_bit - 1] = io_wide;
		hps_status[mcu_bus_pkg::hps_ack_bit]     = io_ack;
	end

endmodule

/* hw/periph_bus_ctrl.sv */
module periph_bus_ctrl (
	input  logic                     clk_sys,
	input  logic                     reset_n,
	input  logic                     cpu_req,
	input  mcu_bus_pkg::bus_addr_t   cpu_addr,
	input  mcu_bus_pkg::bus_data_t   cpu_wdata,
	input  mcu_bus_pkg::bus_strb_t   cpu_wstrb,
	output logic                     cpu_ack,
	output mcu_bus_pkg::bus_data_t   cpu_rdata,
	output logic                     reset_out,
	output mcu_bus_pkg::bus_data_t   reg_wdata,
	output logic                     wr_slot_id,
	output logic                     wr_slot_bridgeaddr,
	output logic                     wr_slot_length,
	output logic                     wr_slot_offset,
	output logic                     wr_slot_ctrl,
	output logic                     wr_hps_io,
	output logic                     irq_clear,
	input  mcu_slot_pkg::slot_id_t   slot_id_q,
	input  mcu_slot_pkg::slot_word_t slot_bridgeaddr_q,
	input  mcu_slot_pkg::slot_word_t slot_length_q,
	input  mcu_slot_pkg::slot_word_t slot_offset_q,
	input  mcu_bus_pkg::bus_data_t   slot_status,
	input  logic                     irq_status,
	input  mcu_slot_pkg::slot_id_t   update_id,
	input  mcu_slot_pkg::slot_word_t update_size,
	input  mcu_slot_pkg::ms_count_t  ms_count,
	input  mcu_bus_pkg::bus_data_t   hps_status
);

	typedef enum logic {st_idle, st_respond} bus_state_t;

	bus_state_t             state;
	logic                   start;    // new access accepted this edge
	logic                   req_hit;  // inside the periph page
	logic                   req_wr;
	logic                   ack_pend; // rdata is in, ack goes out next edge
	mcu_bus_pkg::reg_off_t  req_off;
	mcu_bus_pkg::bus_data_t rd_mux;

	// request stays up through the ack cycle, so hold off until both stages are clear
	assign start = (state == st_idle) && cpu_req && !cpu_ack && !ack_pend;

	// read mux off the latched offset
	always_comb begin
		rd_mux = '0; // anything unmapped reads as zero
		if (req_hit) begin
			case (req_off)
				mcu_bus_pkg::off_slot_id:         rd_mux = mcu_bus_pkg::bus_data_t'(slot_id_q);
				mcu_bus_pkg::off_slot_bridgeaddr: rd_mux = slot_bridgeaddr_q;
				mcu_bus_pkg::off_slot_length:     rd_mux = slot_length_q;
				mcu_bus_pkg::off_slot_offset:     rd_mux = slot_offset_q;
				mcu_bus_pkg::off_slot_ctrl:       rd_mux = slot_status;
				mcu_bus_pkg::off_reset_out:       rd_mux = mcu_bus_pkg::bus_data_t'(reset_out);
				mcu_bus_pkg::off_irq:             rd_mux = mcu_bus_pkg::bus_data_t'(irq_status);
				mcu_bus_pkg::off_update_id:       rd_mux = mcu_bus_pkg::bus_data_t'(update_id);
				mcu_bus_pkg::off_update_size:     rd_mux = update_size;
				mcu_bus_pkg::off_timer:           rd_mux = ms_count;
				mcu_bus_pkg::off_hps_io:          rd_mux = hps_status;
				default:                          rd_mux = '0;
			endcase
		end
	end

	always_ff @(posedge clk_sys or negedge reset_n) begin
		if (!reset_n) begin
			state              <= st_idle;
			req_hit            <= 1'b0;
			req_wr             <= 1'b0;
			ack_pend           <= 1'b0;
			cpu_ack            <= 1'b0;
			reset_out          <= 1'b0;
			wr_slot_id         <= 1'b0;
			wr_slot_bridgeaddr <= 1'b0;
			wr_slot_length     <= 1'b0;
			wr_slot_offset     <= 1'b0;
			wr_slot_ctrl       <= 1'b0;
			wr_hps_io          <= 1'b0;
			irq_clear          <= 1'b0;
		end else begin
			// strobes are single cycle
			wr_slot_id         <= 1'b0;
			wr_slot_bridgeaddr <= 1'b0;
			wr_slot_length     <= 1'b0;
			wr_slot_offset     <= 1'b0;
			wr_slot_ctrl       <= 1'b0;
			wr_hps_io          <= 1'b0;
			irq_clear          <= 1'b0;
			cpu_ack            <= ack_pend; // edge n+2
			ack_pend           <= 1'b0;
			case (state)
				st_idle: begin
					if (start) begin // edge n, latch the decode
						req_hit <= (cpu_addr[31:16] == mcu_bus_pkg::periph_page);
						req_wr  <= |cpu_wstrb;
						state   <= st_respond;
					end
				end
				st_respond: begin // edge n+1
					ack_pend <= 1'b1;
					state    <= st_idle;
					if (req_hit && req_wr) begin
						case (req_off)
							mcu_bus_pkg::off_slot_id:         wr_slot_id         <= 1'b1;
							mcu_bus_pkg::off_slot_bridgeaddr: wr_slot_bridgeaddr <= 1'b1;
							mcu_bus_pkg::off_slot_length:     wr_slot_length     <= 1'b1;
							mcu_bus_pkg::off_slot_offset:     wr_slot_offset     <= 1'b1;
							mcu_bus_pkg::off_slot_ctrl:       wr_slot_ctrl       <= 1'b1;
							mcu_bus_pkg::off_hps_io:          wr_hps_io          <= 1'b1;
							mcu_bus_pkg::off_reset_out:       reset_out <= reg_wdata[0];
							default: ; // dropped
						endcase
					end
					// reading the irq word acks it
					if (req_hit && !req_wr && (req_off == mcu_bus_pkg::off_irq))
						irq_clear <= 1'b1;
				end
				default: state <= st_idle;
			endcase
		end
	end

	// offset, write data and read data
	always_ff @(posedge clk_sys) begin
		if (start) begin
			req_off   <= cpu_addr[15:0];
			reg_wdata <= cpu_wdata; // stays put until the target reg has taken it
		end
		if (state == st_respond)
			cpu_rdata <= rd_mux; // holds after the ack
	end

endmodule

/* hw/mcu_periph_top.sv */
module mcu_periph_top #(
	parameter int unsigned ticks_per_ms = 1000
) (
	input  logic                     clk_sys,
	input  logic                     reset_n,
	input  logic                     clk_74a,
	input  logic                     cpu_req,
	input  mcu_bus_pkg::bus_addr_t   cpu_addr,
	input  mcu_bus_pkg::bus_data_t   cpu_wdata,
	input  mcu_bus_pkg::bus_strb_t   cpu_wstrb,
	output logic                     cpu_ack,
	output mcu_bus_pkg::bus_data_t   cpu_rdata,
	output logic                     reset_out,
	input  logic                     dataslot_update,
	input  mcu_slot_pkg::slot_id_t   dataslot_update_id,
	input  mcu_slot_pkg::slot_word_t dataslot_update_size,
	output logic                     target_dataslot_read,
	output logic                     target_dataslot_write,
	input  logic                     target_dataslot_ack,
	input  logic                     target_dataslot_done,
	input  mcu_slot_pkg::slot_err_t  target_dataslot_err,
	output mcu_slot_pkg::slot_id_t   target_dataslot_id,
	output mcu_slot_pkg::slot_word_t target_dataslot_slotoffset,
	output mcu_slot_pkg::slot_word_t target_dataslot_bridgeaddr,
	output mcu_slot_pkg::slot_word_t target_dataslot_length,
	output logic                     irq,
	output logic                     io_uio,
	output logic                     io_fpga,
	output logic                     io_strobe,
	input  logic                     io_wait,
	input  logic                     io_wide,
	input  mcu_slot_pkg::hps_word_t  io_din,
	output mcu_slot_pkg::hps_word_t  io_dout
);

	mcu_bus_pkg::bus_data_t   reg_wdata; // held from decode until the strobe has landed
	logic                     wr_slot_id, wr_slot_bridgeaddr, wr_slot_length;
	logic                     wr_slot_offset, wr_slot_ctrl, wr_hps_io;
	logic                     irq_clear;
	mcu_bus_pkg::bus_data_t   slot_status;
	mcu_bus_pkg::bus_data_t   hps_status;
	mcu_slot_pkg::slot_id_t   update_id;
	mcu_slot_pkg::slot_word_t update_size;
	mcu_slot_pkg::ms_count_t  ms_count;

	periph_bus_ctrl u_ctrl (
		.clk_sys            (clk_sys),
		.reset_n            (reset_n),
		.cpu_req            (cpu_req),
		.cpu_addr           (cpu_addr),
		.cpu_wdata          (cpu_wdata),
		.cpu_wstrb          (cpu_wstrb),
		.cpu_ack            (cpu_ack),
		.cpu_rdata          (cpu_rdata),
		.reset_out          (reset_out),
		.reg_wdata          (reg_wdata),
		.wr_slot_id         (wr_slot_id),
		.wr_slot_bridgeaddr (wr_slot_bridgeaddr),
		.wr_slot_length     (wr_slot_length),
		.wr_slot_offset     (wr_slot_offset),
		.wr_slot_ctrl       (wr_slot_ctrl),
		.wr_hps_io          (wr_hps_io),
		.irq_clear          (irq_clear),
		.slot_id_q          (target_dataslot_id), // read back straight off the outputs
		.slot_bridgeaddr_q  (target_dataslot_bridgeaddr),
		.slot_length_q      (target_dataslot_length),
		.slot_offset_q      (target_dataslot_slotoffset),
		.slot_status        (slot_status),
		.irq_status         (irq),
		.update_id          (update_id),
		.update_size        (update_size),
		.ms_count           (ms_count),
		.hps_status         (hps_status)
	);

	target_slot_regs u_slot_regs (
		.clk_sys            (clk_sys),
		.reset_n            (reset_n),
		.reg_wdata          (reg_wdata),
		.wr_slot_id         (wr_slot_id),
		.wr_slot_bridgeaddr (wr_slot_bridgeaddr),
		.wr_slot_length     (wr_slot_length),
		.wr_slot_offset     (wr_slot_offset),
		.wr_slot_ctrl       (wr_slot_ctrl),
		.slot_ack           (target_dataslot_ack),
		.slot_done          (target_dataslot_done),
		.slot_err           (target_dataslot_err),
		.slot_id_q          (target_dataslot_id),
		.slot_bridgeaddr_q  (target_dataslot_bridgeaddr),
		.slot_length_q      (target_dataslot_length),
		.slot_offset_q      (target_dataslot_slotoffset),
		.slot_read          (target_dataslot_read),
		.slot_write         (target_dataslot_write),
		.slot_status        (slot_status)
	);

	slot_update_sync u_update_sync (
		.clk_sys        (clk_sys),
		.clk_74a        (clk_74a),
		.reset_n        (reset_n),
		.update_pulse   (dataslot_update),
		.update_id_in   (dataslot_update_id),
		.update_size_in (dataslot_update_size),
		.irq_clear      (irq_clear),
		.irq_out        (irq), // same line feeds the irq status read
		.update_id      (update_id),
		.update_size    (update_size)
	);

	ms_timer #(
		.ticks_per_ms (ticks_per_ms)
	) u_timer (
		.clk_sys  (clk_sys),
		.reset_n  (reset_n),
		.ms_count (ms_count)
	);

	hps_io_port u_hps_io (
		.clk_sys    (clk_sys),
		.reset_n    (reset_n),
		.reg_wdata  (reg_wdata),
		.wr_hps_io  (wr_hps_io),
		.io_wait    (io_wait),
		.io_wide    (io_wide),
		.io_din     (io_din),
		.io_dout    (io_dout),
		.io_uio     (io_uio),
		.io_fpga    (io_fpga),
		.io_strobe  (io_strobe),
		.hps_status (hps_status)
	);

endmodule

/* sim/mcu_periph_assert.sv */
module mcu_periph_assert (
	input logic clk_sys,
	input logic reset_n,
	input logic cpu_req,
	input logic cpu_ack,
	input logic slot_read,
	input logic slot_write
);

	// ack never stretches
	ack_single: assert property (@(posedge clk_sys) disable iff (!reset_n)
		cpu_ack |=> !cpu_ack)
		else $error("cpu_ack high for more than one cycle");

	// req seen at edge n, ack driven at edge n+2, sampled one edge later
	ack_latency: assert property (@(posedge clk_sys) disable iff (!reset_n)
		$rose(cpu_req) |=> !cpu_ack ##1 !cpu_ack ##1 cpu_ack)
		else $error("cpu_ack not two cycles after the request");

	read_pulse: assert property (@(posedge clk_sys) disable iff (!reset_n)
		slot_read |=> !slot_read)
		else $error("target_dataslot_read longer than one cycle");

	write_pulse: assert property (@(posedge clk_sys) disable iff (!reset_n)
		slot_write |=> !slot_write)
		else $error("target_dataslot_write longer than one cycle");

endmodule

// the cmd pulses only exist at the top level, so attach there
bind mcu_periph_top mcu_periph_assert u_bus_assert (
	.clk_sys    (clk_sys),
	.reset_n    (reset_n),
	.cpu_req    (cpu_req),
	.cpu_ack    (cpu_ack),
	.slot_read  (target_dataslot_read),
	.slot_write (target_dataslot_write)
);

/* sim/mcu_periph_tb.sv */
module mcu_periph_tb;

	localparam int unsigned tb_ticks = 10; // clk_sys cycles per ms
	localparam int tbl_len = 16;
	localparam int ack_limit = 10;  // cycles until cpu_ack
	localparam int wait_limit = 40; // cycles for the slower waits

	typedef struct packed {
		logic                   wr;
		mcu_bus_pkg::reg_off_t  off;
		mcu_bus_pkg::bus_data_t wdata;
		mcu_bus_pkg::bus_data_t rexp;
		mcu_bus_pkg::bus_data_t mask;
	} access_t;

	logic clk_sys, clk_74a, reset_n;
	logic cpu_req, cpu_ack, reset_out;
	mcu_bus_pkg::bus_addr_t cpu_addr;
	mcu_bus_pkg::bus_data_t cpu_wdata, cpu_rdata;
	mcu_bus_pkg::bus_strb_t cpu_wstrb;
	logic dataslot_update;
	mcu_slot_pkg::slot_id_t dataslot_update_id, target_dataslot_id;
	mcu_slot_pkg::slot_word_t dataslot_update_size;
	logic target_dataslot_read, target_dataslot_write;
	logic target_dataslot_ack, target_dataslot_done;
	mcu_slot_pkg::slot_err_t target_dataslot_err;
	mcu_slot_pkg::slot_word_t target_dataslot_slotoffset, target_dataslot_bridgeaddr;
	mcu_slot_pkg::slot_word_t target_dataslot_length;
	logic irq, io_uio, io_fpga, io_strobe, io_wait, io_wide;
	mcu_slot_pkg::hps_word_t io_din, io_dout;

	access_t tbl [tbl_len];
	logic [31:0] rng;
	int unsigned cyc = 0;       // clk_sys edges since start
	int unsigned ack_cyc;       // cyc at the last ack
	int unsigned rd_pulses = 0;
	int unsigned wr_pulses = 0;

	mcu_periph_top #(.ticks_per_ms(tb_ticks)) dut0 (.*);

	initial begin
		clk_sys = 1'b0;
		forever #50 clk_sys = ~clk_sys;
	end

	initial begin
		clk_74a = 1'b0;
		forever #37 clk_74a = ~clk_74a; // bridge clock, unrelated to clk_sys
	end

	always @(posedge clk_sys) cyc <= cyc + 1;

	// count cmd pulse cycles mid period
	always @(negedge clk_sys) begin
		if (target_dataslot_read)
			rd_pulses <= rd_pulses + 1;
		if (target_dataslot_write)
			wr_pulses <= wr_pulses + 1;
	end

	function automatic logic [31:0] next_random();
		rng = rng ^ (rng << 13);
		rng = rng ^ (rng >> 17);
		rng = rng ^ (rng << 5);
		return rng;
	endfunction

	function automatic access_t make_entry(input logic wr, input mcu_bus_pkg::reg_off_t off,
			input mcu_bus_pkg::bus_data_t wdata, input mcu_bus_pkg::bus_data_t rexp);
		access_t e;
		e.wr    = wr;
		e.off   = off;
		e.wdata = wdata;
		e.rexp  = rexp;
		e.mask  = wr ? 32'h0 : 32'hffff_ffff; // writes have nothing to compare
		return e;
	endfunction

	function automatic mcu_bus_pkg::bus_addr_t page_addr(input mcu_bus_pkg::reg_off_t off);
		return {mcu_bus_pkg::periph_page, off};
	endfunction

	task automatic report_timeout(input string what);
		$display("timeout at %0t while waiting for %s", $time, what);
		$display("CHECKS FAILED");
		$fatal(1, "wait ran out");
	endtask

	task automatic check_word(input string name, input mcu_bus_pkg::bus_data_t got,
			input mcu_bus_pkg::bus_data_t exp);
		if (got !== exp) begin
			$display("CHECK FAILED time %0t %s got %h expected %h", $time, name, got, exp);
			$display("CHECKS FAILED");
			$fatal(1, "value mismatch");
		end
	endtask

	task automatic check_id(input string name, input mcu_slot_pkg::slot_id_t got,
			input mcu_slot_pkg::slot_id_t exp);
		if (got !== exp) begin
			$display("CHECK FAILED time %0t %s got %h expected %h", $time, name, got, exp);
			$display("CHECKS FAILED");
			$fatal(1, "value mismatch");
		end
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			$display("CHECK FAILED time %0t %s got %b expected %b", $time, name, got, exp);
			$display("CHECKS FAILED");
			$fatal(1, "value mismatch");
		end
	endtask

	// one access, req held until ack, returns the read data
	task automatic bus_access(input logic wr, input mcu_bus_pkg::bus_addr_t addr,
			input mcu_bus_pkg::bus_data_t wdata, output mcu_bus_pkg::bus_data_t rd);
		int n;
		@(posedge clk_sys);
		#10;
		cpu_req   = 1'b1;
		cpu_addr  = addr;
		cpu_wdata = wdata;
		cpu_wstrb = wr ? 4'hf : 4'h0;
		for (n = 0; n < ack_limit && !cpu_ack; n++) begin
			@(posedge clk_sys);
			#10;
		end
		if (!cpu_ack)
			report_timeout("cpu_ack");
		rd      = cpu_rdata; // valid in the ack cycle
		ack_cyc = cyc;
		cpu_req   = 1'b0;
		cpu_wstrb = 4'h0;
	endtask

	task automatic wait_irq(input logic level);
		int n;
		for (n = 0; n < wait_limit && irq !== level; n++) begin
			@(posedge clk_sys);
			#10;
		end
		if (irq !== level)
			report_timeout(level ? "irq to rise" : "irq to fall");
	endtask

	task automatic wait_strobe(input logic level);
		int n;
		for (n = 0; n < wait_limit && io_strobe !== level; n++) begin
			@(posedge clk_sys);
			#10;
		end
		if (io_strobe !== level)
			report_timeout(level ? "io_strobe to rise" : "io_strobe to fall");
	endtask

	initial begin
		mcu_bus_pkg::bus_data_t rdata, v_id, v_ba, v_len, v_off, st_exp, t0, t1, hps_wd, r;
		mcu_slot_pkg::slot_id_t upd_id;
		mcu_slot_pkg::slot_word_t upd_size;
		int unsigned rd0, wr0, c, k;
		rng = 32'h98a3;
		reset_n = 1'b0;
		cpu_req = 1'b0;
		cpu_addr = '0;
		cpu_wdata = '0;
		cpu_wstrb = '0;
		dataslot_update = 1'b0;
		dataslot_update_id = '0;
		dataslot_update_size = '0;
		io_wait = 1'b0;
		r = next_random(); // target side status and hps inputs
		target_dataslot_ack = r[0];
		target_dataslot_done = r[1];
		target_dataslot_err = r[4:2];
		io_wide = r[5];
		io_din = r[31:16];
		repeat (5) @(posedge clk_sys);
		#10;
		reset_n = 1'b1;
		check_bit("cpu_ack", cpu_ack, 1'b0);
		check_bit("target_dataslot_read", target_dataslot_read, 1'b0);
		check_bit("target_dataslot_write", target_dataslot_write, 1'b0);
		check_bit("irq", irq, 1'b0);
		check_bit("io_strobe", io_strobe, 1'b0);
		check_bit("io_fpga", io_fpga, 1'b0);
		check_bit("io_uio", io_uio, 1'b0);
		check_bit("reset_out", reset_out, 1'b0);

		v_id = next_random();
		v_ba = next_random();
		v_len = next_random();
		v_off = next_random();
		r = next_random();
		// err in 2..0, done in 3, ack in 4
		st_exp = 32'(target_dataslot_err) | (32'(target_dataslot_done) << 3)
			| (32'(target_dataslot_ack) << 4);
		tbl[0]  = make_entry(1'b1, mcu_bus_pkg::off_slot_id, v_id, '0);
		tbl[1]  = make_entry(1'b0, mcu_bus_pkg::off_slot_id, '0, {16'h0, v_id[15:0]});
		tbl[2]  = make_entry(1'b1, mcu_bus_pkg::off_slot_bridgeaddr, v_ba, '0);
		tbl[3]  = make_entry(1'b0, mcu_bus_pkg::off_slot_bridgeaddr, '0, v_ba);
		tbl[4]  = make_entry(1'b1, mcu_bus_pkg::off_slot_length, v_len, '0);
		tbl[5]  = make_entry(1'b0, mcu_bus_pkg::off_slot_length, '0, v_len);
		tbl[6]  = make_entry(1'b1, mcu_bus_pkg::off_slot_offset, v_off, '0);
		tbl[7]  = make_entry(1'b0, mcu_bus_pkg::off_slot_offset, '0, v_off);
		tbl[8]  = make_entry(1'b0, mcu_bus_pkg::off_slot_ctrl, '0, st_exp);
		tbl[9]  = make_entry(1'b1, mcu_bus_pkg::off_reset_out, {r[31:1], 1'b1}, '0);
		tbl[10] = make_entry(1'b0, mcu_bus_pkg::off_reset_out, '0, 32'h1);
		tbl[11] = make_entry(1'b1, mcu_bus_pkg::off_reset_out, {r[30:0], 1'b0}, '0);
		tbl[12] = make_entry(1'b0, mcu_bus_pkg::off_reset_out, '0, 32'h0);
		tbl[13] = make_entry(1'b0, 16'hff00, '0, 32'h0); // hole in the page
		tbl[14] = make_entry(1'b1, 16'hffe0, r, '0);     // dropped
		tbl[15] = make_entry(1'b0, 16'hffe0, '0, 32'h0);
		for (int i = 0; i < tbl_len; i++) begin
			bus_access(tbl[i].wr, page_addr(tbl[i].off), tbl[i].wdata, rdata);
			if (!tbl[i].wr)
				check_word($sformatf("cpu_rdata @%h", tbl[i].off),
					rdata & tbl[i].mask, tbl[i].rexp & tbl[i].mask);
			else if (tbl[i].off == mcu_bus_pkg::off_reset_out)
				check_bit("reset_out", reset_out, tbl[i].wdata[0]);
		end
		check_id("target_dataslot_id", target_dataslot_id, v_id[15:0]);
		check_word("target_dataslot_bridgeaddr", target_dataslot_bridgeaddr, v_ba);
		check_word("target_dataslot_length", target_dataslot_length, v_len);
		check_word("target_dataslot_slotoffset", target_dataslot_slotoffset, v_off);
		// outside the page, write must not land, read is zero
		bus_access(1'b1, {16'h0000, mcu_bus_pkg::off_slot_id}, ~v_id, rdata);
		check_id("target_dataslot_id", target_dataslot_id, v_id[15:0]);
		bus_access(1'b0, {16'h1234, mcu_bus_pkg::off_slot_length}, '0, rdata);
		check_word("cpu_rdata outside page", rdata, 32'h0);

		// cmd bits 1, 2, then both
		for (k = 1; k <= 3; k++) begin
			rd0 = rd_pulses;
			wr0 = wr_pulses;
			bus_access(1'b1, page_addr(mcu_bus_pkg::off_slot_ctrl), 32'(k), rdata);
			repeat (3) @(posedge clk_sys);
			#10;
			check_word("target_dataslot_read cycles", 32'(rd_pulses - rd0), 32'(k & 1));
			check_word("target_dataslot_write cycles", 32'(wr_pulses - wr0), 32'((k >> 1) & 1));
		end

		r = next_random();
		upd_id = r[15:0];
		upd_size = next_random();
		@(posedge clk_74a);
		#10;
		dataslot_update = 1'b1; // one clk_74a cycle
		dataslot_update_id = upd_id;
		dataslot_update_size = upd_size;
		@(posedge clk_74a);
		#10;
		dataslot_update = 1'b0;
		wait_irq(1'b1);
		bus_access(1'b0, page_addr(mcu_bus_pkg::off_update_id), '0, rdata);
		check_word("update id", rdata, {16'h0, upd_id});
		bus_access(1'b0, page_addr(mcu_bus_pkg::off_update_size), '0, rdata);
		check_word("update size", rdata, upd_size);
		bus_access(1'b0, page_addr(mcu_bus_pkg::off_irq), '0, rdata); // clears
		check_word("irq status", rdata, 32'h1);
		wait_irq(1'b0);
		bus_access(1'b0, page_addr(mcu_bus_pkg::off_irq), '0, rdata);
		check_word("irq status", rdata, 32'h0);

		bus_access(1'b0, page_addr(mcu_bus_pkg::off_timer), '0, t0);
		c = ack_cyc;
		r = next_random();
		k = 20 + (r % 40);
		repeat (k) @(posedge clk_sys);
		bus_access(1'b0, page_addr(mcu_bus_pkg::off_timer), '0, t1);
		c = (ack_cyc - c) / tb_ticks; // whole ms in the gap
		if (t1 - t0 != 32'(c + 1)) // one extra tick when a boundary falls inside
			check_word("ms_count step", t1 - t0, 32'(c));

		r = next_random();
		hps_wd = {11'h0, r[20:18], 1'b1, 1'b0, r[15:0]}; // ss2 ss1 ss0, clk high
		bus_access(1'b1, page_addr(mcu_bus_pkg::off_hps_io), hps_wd, rdata);
		check_word("io_dout", 32'(io_dout), {16'h0, hps_wd[15:0]});
		check_bit("io_fpga", io_fpga, hps_wd[18] & ~hps_wd[19]);
		check_bit("io_uio", io_uio, hps_wd[20] & ~hps_wd[19]);
		wait_strobe(1'b1);
		wait_strobe(1'b0);
		bus_access(1'b0, page_addr(mcu_bus_pkg::off_hps_io), '0, rdata);
		check_word("hps status", rdata, {14'h0, hps_wd[17], io_wide, io_din}); // ack in 17

		$display("ALL CHECKS PASSED");
		$finish;
	end

endmodule

/* compile.f */
common/mcu_bus_pkg.sv
common/mcu_slot_pkg.sv
hw/dataslot/target_slot_regs.sv
hw/dataslot/slot_update_sync.sv
hw/ms_timer.sv
hw/hps_io_port.sv
hw/periph_bus_ctrl.sv
hw/mcu_periph_top.sv
sim/mcu_periph_assert.sv
sim/mcu_periph_tb.sv

/* run_sim.sh */
#!/bin/sh
# build the testbench with verilator, run it and look for the pass line
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal --top-module mcu_periph_tb -f compile.f
out=$(./obj_dir/Vmcu_periph_tb 2>&1 || true)
printf '%s\n' "$out"
if printf '%s\n' "$out" | grep -qx 'ALL CHECKS PASSED'; then
	echo "simulation passed"
	exit 0
else
	echo "simulation failed"
	exit 1
fi
